/* dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// byte address and data word
`define DC_ADDR_W 32
`define DC_WORD_W 32

// one line holds four words
`define DC_LINE_W 128

// direct-mapped geometry
`define DC_LINES 64
`define DC_IDX_W 6

// address bits above index and the 4 offset bits
`define DC_TAG_W 22

`endif

/* dcache_pkg.sv */
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0] addr_t;
    typedef logic [`DC_WORD_W-1:0] word_t;
    typedef logic [`DC_LINE_W-1:0] line_t;

    // one enable bit per byte lane, active high
    typedef logic [`DC_WORD_W/8-1:0] bmask_t;

    typedef logic [`DC_IDX_W-1:0] idx_t;
    typedef logic [`DC_TAG_W-1:0] tag_t;

    // bit 2 selects zero-extension, bits 1..0 the size
    typedef logic [2:0] acc_ctrl_t;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } acc_size_e;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        READ_MISS,
        WBUF_WAIT,
        CACH_WRITE
    } dc_state_e;

endpackage

/* dcache_store_if.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

interface dcache_store_if;

    // lookup and fill request
    logic               we;
    dcache_pkg::idx_t   idx;
    dcache_pkg::tag_t   tag;
    dcache_pkg::line_t  wline;

    // result of the lookup from the cycle before
    logic               hit;
    dcache_pkg::line_t  rline;

    modport ctrl (
        output we,
        output idx,
        output tag,
        output wline,
        input  hit,
        input  rline
    );

    modport store (
        input  we,
        input  idx,
        input  tag,
        input  wline,
        output hit,
        output rline
    );

endinterface

/* mem_req_decode.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module mem_req_decode (
    input  dcache_pkg::addr_t     i_addr,
    input  dcache_pkg::acc_ctrl_t i_ctrl,
    input  dcache_pkg::word_t     i_wdata,
    output dcache_pkg::bmask_t    o_mask,
    output dcache_pkg::word_t     o_wdata_rep
);

    dcache_pkg::acc_size_e size;

    assign size = dcache_pkg::acc_size_e'(i_ctrl[1:0]);

    // lanes follow the low address bits, data is copied into every lane
    always_comb begin
        case (size)
            dcache_pkg::SZ_BYTE: begin
                o_mask      = 4'b0001 << i_addr[1:0];
                o_wdata_rep = {4{i_wdata[7:0]}};
            end
            dcache_pkg::SZ_HALF: begin
                o_mask      = 4'b0011 << {i_addr[1], 1'b0};
                o_wdata_rep = {2{i_wdata[`DC_WORD_W/2-1:0]}};
            end
            default: begin
                o_mask      = 4'b1111;
                o_wdata_rep = i_wdata;
            end
        endcase
    end

endmodule

/* dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                  o_clk,
    input  logic                  i_rrst_x,
    input  logic                  i_rd_en,
    input  logic                  i_wr_en,
    input  dcache_pkg::addr_t     i_addr,
    input  dcache_pkg::word_t     i_wdata_rep,
    input  dcache_pkg::bmask_t    i_mask,
    input  logic                  i_dram_stall,
    input  dcache_pkg::line_t     i_dram_rdata,
    output logic                  o_busy,
    output dcache_pkg::line_t     o_line,
    output dcache_pkg::addr_t     o_req_addr,
    output logic                  o_dram_le,
    output logic                  o_dram_we,
    output dcache_pkg::addr_t     o_dram_addr,
    output dcache_pkg::word_t     o_dram_wdata,
    output dcache_pkg::bmask_t    o_dram_mask,
    dcache_store_if.ctrl          store
);

    dcache_pkg::dc_state_e state;
    dcache_pkg::dc_state_e state_nx;

    dcache_pkg::addr_t  r_addr;
    dcache_pkg::addr_t  r_ld_addr;
    dcache_pkg::addr_t  cur_addr;
    dcache_pkg::word_t  r_wdata;
    dcache_pkg::bmask_t r_mask;
    dcache_pkg::line_t  r_line;
    dcache_pkg::line_t  line_nx;
    dcache_pkg::line_t  slot_mask;
    dcache_pkg::line_t  slot_data;
    dcache_pkg::line_t  merged;

    logic [`DC_WORD_W-1:0] byte_bits;
    logic                  idle;
    logic                  wbuf_full;
    logic                  wbuf_empty;
    logic                  wbuf_push;

    assign idle = (state == dcache_pkg::IDLE);

    // the pending write retires in the first cycle without stall
    assign wbuf_empty = !wbuf_full || !i_dram_stall;

    // lookup uses the core address on accept, the latched one afterwards
    assign cur_addr  = idle ? i_addr : r_addr;
    assign store.idx = cur_addr[`DC_IDX_W+3:4];
    assign store.tag = cur_addr[`DC_ADDR_W-1:`DC_IDX_W+4];

    // merge the latched word into its slot of the cached line
    assign byte_bits = {{8{r_mask[3]}}, {8{r_mask[2]}}, {8{r_mask[1]}}, {8{r_mask[0]}}};
    assign slot_mask = dcache_pkg::line_t'(byte_bits) << {r_addr[3:2], 5'b00000};
    assign slot_data = dcache_pkg::line_t'(r_wdata & byte_bits) << {r_addr[3:2], 5'b00000};
    assign merged    = (store.rline & ~slot_mask) | slot_data;

    always_comb begin
        state_nx    = state;
        line_nx     = r_line;
        wbuf_push   = 1'b0;
        o_dram_le   = 1'b0;
        store.we    = 1'b0;
        store.wline = i_dram_rdata;
        case (state)
            dcache_pkg::IDLE: begin
                if (i_wr_en) begin
                    if (wbuf_empty) begin
                        wbuf_push = 1'b1;
                        state_nx  = dcache_pkg::CACH_WRITE;
                    end else begin
                        state_nx = dcache_pkg::WBUF_WAIT;
                    end
                end else if (i_rd_en) begin
                    state_nx = dcache_pkg::READ;
                end
            end
            dcache_pkg::READ: begin
                if (store.hit) begin
                    line_nx  = store.rline;
                    state_nx = dcache_pkg::IDLE;
                end else if (!i_dram_stall) begin
                    o_dram_le = 1'b1;
                    state_nx  = dcache_pkg::READ_MISS;
                end
            end
            dcache_pkg::READ_MISS: begin
                // line is only valid in the cycle stall drops
                if (!i_dram_stall) begin
                    line_nx  = i_dram_rdata;
                    store.we = 1'b1;
                    state_nx = dcache_pkg::IDLE;
                end
            end
            dcache_pkg::WBUF_WAIT: begin
                if (wbuf_empty) begin
                    wbuf_push = 1'b1;
                    state_nx  = dcache_pkg::CACH_WRITE;
                end
            end
            dcache_pkg::CACH_WRITE: begin
                // no allocate on a store miss
                if (store.hit) begin
                    store.we    = 1'b1;
                    store.wline = merged;
                end
                state_nx = dcache_pkg::IDLE;
            end
            default: begin
                state_nx = dcache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge o_clk) begin
        if (!i_rrst_x) begin
            state     <= dcache_pkg::IDLE;
            wbuf_full <= 1'b0;
        end else begin
            state <= state_nx;
            if (wbuf_push) begin
                wbuf_full <= 1'b1;
            end else if (!i_dram_stall) begin
                wbuf_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge o_clk) begin
        if (idle && (i_rd_en || i_wr_en)) begin
            r_addr  <= i_addr;
            r_wdata <= i_wdata_rep;
            r_mask  <= i_mask;
        end
        // kept apart so load data holds across stores
        if (idle && i_rd_en) begin
            r_ld_addr <= i_addr;
        end
        r_line <= line_nx;
    end

    assign o_busy     = !idle;
    assign o_line     = r_line;
    assign o_req_addr = r_ld_addr;

    assign o_dram_we    = wbuf_push;
    assign o_dram_addr  = o_dram_le ? {r_addr[`DC_ADDR_W-1:4], 4'b0000}
                                    : {cur_addr[`DC_ADDR_W-1:2], 2'b00};
    assign o_dram_wdata = idle ? i_wdata_rep : r_wdata;
    assign o_dram_mask  = idle ? i_mask : r_mask;

    // the DRAM only samples pulses while it is not stalled
    a_no_pulse_under_stall : assert property (
        @(posedge o_clk) disable iff (!i_rrst_x)
        (o_dram_le || o_dram_we) |-> !i_dram_stall
    ) else $error("dcache_ctrl: DRAM pulse while stall is high");

    a_le_we_exclusive : assert property (
        @(posedge o_clk) disable iff (!i_rrst_x)
        !(o_dram_le && o_dram_we)
    ) else $error("dcache_ctrl: line read and word write in the same cycle");

endmodule

/* dcache_store.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_store (
    input  logic          o_clk,
    input  logic          i_rrst_x,
    dcache_store_if.store port
);

    // synchronous tag and data arrays
    dcache_pkg::line_t data_mem [`DC_LINES];
    dcache_pkg::tag_t  tag_mem  [`DC_LINES];

    logic [`DC_LINES-1:0] valid;
    logic                 r_valid;
    dcache_pkg::tag_t     r_tag;
    dcache_pkg::tag_t     rd_tag;

    always_ff @(posedge o_clk) begin
        if (port.we) begin
            data_mem[port.idx] <= port.wline;
            tag_mem[port.idx]  <= port.tag;
        end
        port.rline <= data_mem[port.idx];
        rd_tag     <= tag_mem[port.idx];
        // compared against the stored tag one cycle later
        r_tag      <= port.tag;
    end

    always_ff @(posedge o_clk) begin
        if (!i_rrst_x) begin
            valid   <= '0;
            r_valid <= 1'b0;
        end else begin
            if (port.we) begin
                valid[port.idx] <= 1'b1;
            end
            r_valid <= valid[port.idx];
        end
    end

    assign port.hit = r_valid && (rd_tag == r_tag);

    // reset held for two cycles leaves the controller idle
    a_no_write_in_reset : assert property (
        @(posedge o_clk)
        (!i_rrst_x && $past(!i_rrst_x)) |-> !port.we
    ) else $error("dcache_store: line written while reset is active");

endmodule

/* load_align.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module load_align (
    input  logic                  o_clk,
    input  logic                  i_rd_en,
    input  dcache_pkg::line_t     i_line,
    input  dcache_pkg::addr_t     i_addr,
    input  dcache_pkg::acc_ctrl_t i_ctrl,
    output dcache_pkg::word_t     o_rdata
);

    dcache_pkg::acc_ctrl_t r_ctrl;
    dcache_pkg::line_t     shifted;
    dcache_pkg::word_t     word;
    logic                  zext;

    // control code of the load in flight
    always_ff @(posedge o_clk) begin
        if (i_rd_en) begin
            r_ctrl <= i_ctrl;
        end
    end

    // byte offset within the line
    assign shifted = i_line >> {i_addr[3:0], 3'b000};
    assign word    = shifted[`DC_WORD_W-1:0];
    assign zext    = r_ctrl[2];

    always_comb begin
        case (dcache_pkg::acc_size_e'(r_ctrl[1:0]))
            dcache_pkg::SZ_BYTE: begin
                o_rdata = zext ? {24'h000000, word[7:0]} : {{24{word[7]}}, word[7:0]};
            end
            dcache_pkg::SZ_HALF: begin
                o_rdata = zext ? {16'h0000, word[15:0]} : {{16{word[15]}}, word[15:0]};
            end
            default: begin
                o_rdata = word;
            end
        endcase
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top (
    input  logic                  o_clk,
    input  logic                  i_rrst_x,
    // core side
    input  logic                  i_rd_en,
    input  logic                  i_wr_en,
    input  dcache_pkg::addr_t     i_addr,
    input  dcache_pkg::word_t     i_wdata,
    input  dcache_pkg::acc_ctrl_t i_ctrl,
    output dcache_pkg::word_t     o_rdata,
    output logic                  o_busy,
    // DRAM side
    output logic                  o_dram_le,
    output logic                  o_dram_we,
    output dcache_pkg::addr_t     o_dram_addr,
    output dcache_pkg::word_t     o_dram_wdata,
    output dcache_pkg::bmask_t    o_dram_mask,
    input  logic                  i_dram_stall,
    input  dcache_pkg::line_t     i_dram_rdata
);

    dcache_pkg::bmask_t mask;
    dcache_pkg::word_t  wdata_rep;
    dcache_pkg::line_t  res_line;
    dcache_pkg::addr_t  req_addr;

    dcache_store_if store_bus ();

    mem_req_decode u_decode (
        .i_addr      (i_addr),
        .i_ctrl      (i_ctrl),
        .i_wdata     (i_wdata),
        .o_mask      (mask),
        .o_wdata_rep (wdata_rep)
    );

    dcache_ctrl u_ctrl (
        .o_clk        (o_clk),
        .i_rrst_x     (i_rrst_x),
        .i_rd_en      (i_rd_en),
        .i_wr_en      (i_wr_en),
        .i_addr       (i_addr),
        .i_wdata_rep  (wdata_rep),
        .i_mask       (mask),
        .i_dram_stall (i_dram_stall),
        .i_dram_rdata (i_dram_rdata),
        .o_busy       (o_busy),
        .o_line       (res_line),
        .o_req_addr   (req_addr),
        .o_dram_le    (o_dram_le),
        .o_dram_we    (o_dram_we),
        .o_dram_addr  (o_dram_addr),
        .o_dram_wdata (o_dram_wdata),
        .o_dram_mask  (o_dram_mask),
        .store        (store_bus.ctrl)
    );

    dcache_store u_store (
        .o_clk    (o_clk),
        .i_rrst_x (i_rrst_x),
        .port     (store_bus.store)
    );

    load_align u_result (
        .o_clk   (o_clk),
        .i_rd_en (i_rd_en),
        .i_line  (res_line),
        .i_addr  (req_addr),
        .i_ctrl  (i_ctrl),
        .o_rdata (o_rdata)
    );

endmodule

/* tb_dram_model.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module tb_dram_model (
    input  logic               o_clk,
    input  logic               i_rrst_x,
    input  logic               i_le,
    input  logic               i_we,
    input  dcache_pkg::addr_t  i_addr,
    input  dcache_pkg::word_t  i_wdata,
    input  dcache_pkg::bmask_t i_mask,
    output logic               o_stall,
    output dcache_pkg::line_t  o_rdata
);

    dcache_pkg::word_t mem [1024];

    logic [31:0] lfsr;
    logic [1:0]  draw;
    logic [2:0]  cnt;
    logic        rd_pend;
    logic [9:0]  rd_base;
    logic [9:0]  wr_idx;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] nx;
        if (s[0]) begin
            nx = (s >> 1) ^ 32'h80200003;
        end else begin
            nx = s >> 1;
        end
        return nx;
    endfunction

    initial begin
        lfsr    = 32'hae75;
        o_stall = 1'b0;
        o_rdata = '0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (32'(i) << 2) ^ 32'h5a5a0000;
        end
    end

    always @(posedge o_clk) begin
        if (!i_rrst_x) begin
            o_stall <= 1'b0;
            rd_pend <= 1'b0;
            cnt     <= '0;
        end else if (i_le || i_we) begin
            // two random bits give a stall of 2 to 5 cycles
            lfsr    = lfsr_step(lfsr);
            draw[0] = lfsr[0];
            lfsr    = lfsr_step(lfsr);
            draw[1] = lfsr[0];
            cnt     <= 3'd1 + 3'(draw);
            o_stall <= 1'b1;
            rd_pend <= i_le;
            rd_base = {i_addr[11:4], 2'b00};
            wr_idx  = i_addr[11:2];
            if (i_we) begin
                for (int b = 0; b < `DC_WORD_W/8; b++) begin
                    if (i_mask[b]) begin
                        mem[wr_idx][8*b +: 8] = i_wdata[8*b +: 8];
                    end
                end
            end
        end else if (o_stall) begin
            if (cnt == 3'd0) begin
                o_stall <= 1'b0;
                // line shows up together with the falling stall
                if (rd_pend) begin
                    o_rdata <= {mem[rd_base + 3], mem[rd_base + 2],
                                mem[rd_base + 1], mem[rd_base]};
                end
            end else begin
                cnt <= cnt - 3'd1;
            end
        end
    end

endmodule

/* tb_dcache.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module tb_dcache;

    logic                  o_clk = 1'b0;
    logic                  i_rrst_x;
    logic                  i_rd_en;
    logic                  i_wr_en;
    dcache_pkg::addr_t     i_addr;
    dcache_pkg::word_t     i_wdata;
    dcache_pkg::acc_ctrl_t i_ctrl;
    dcache_pkg::word_t     o_rdata;
    logic                  o_busy;
    logic                  o_dram_le;
    logic                  o_dram_we;
    dcache_pkg::addr_t     o_dram_addr;
    dcache_pkg::word_t     o_dram_wdata;
    dcache_pkg::bmask_t    o_dram_mask;
    logic                  i_dram_stall;
    dcache_pkg::line_t     i_dram_rdata;

    // reference image of the DRAM contents
    dcache_pkg::word_t ref_mem [1024];

    string              test_name;
    int                 err_cnt;
    int                 test_err_start;
    int                 tests_run;
    int                 tests_failed;
    logic               any_req;
    dcache_pkg::addr_t  exp_line_addr;
    dcache_pkg::addr_t  exp_waddr;
    dcache_pkg::bmask_t exp_mask;
    dcache_pkg::word_t  exp_wdata;
    int                 le_seen;
    int                 we_seen;
    int                 busy_cycles;

    // finished request gets checked at the next rising edge
    logic               done;
    logic               done_load;
    dcache_pkg::word_t  done_rdata;
    int                 done_le_exp;
    int                 done_le;
    int                 done_we;
    int                 done_busy;

    dcache_top DUT (.*);

    tb_dram_model u_dram (
        .o_clk    (o_clk),
        .i_rrst_x (i_rrst_x),
        .i_le     (o_dram_le),
        .i_we     (o_dram_we),
        .i_addr   (o_dram_addr),
        .i_wdata  (o_dram_wdata),
        .i_mask   (o_dram_mask),
        .o_stall  (i_dram_stall),
        .o_rdata  (i_dram_rdata)
    );

    initial begin
        forever #20 o_clk = ~o_clk;
    end

    task automatic log_mismatch(input string what, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        err_cnt++;
        $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h",
                 test_name, what, exp_val, act_val);
    endtask

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("%s: %s", test_name, msg);
    endtask

    a_quiet_after_reset : assert property (@(posedge o_clk) disable iff (!i_rrst_x)
        !any_req |-> !(o_busy || o_dram_le || o_dram_we))
        else log_mismatch("busy/le/we before first request", 32'd0,
                          {29'd0, $sampled(o_busy), $sampled(o_dram_le), $sampled(o_dram_we)});
    a_no_pulse_stalled : assert property (@(posedge o_clk) disable iff (!i_rrst_x)
        (o_dram_le || o_dram_we) |-> !i_dram_stall)
        else report_failure("DRAM pulse issued while stall was high");
    a_one_pulse_kind : assert property (@(posedge o_clk) disable iff (!i_rrst_x)
        !(o_dram_le && o_dram_we))
        else report_failure("line read and word write pulsed in the same cycle");
    a_line_addr : assert property (@(posedge o_clk) disable iff (!i_rrst_x)
        o_dram_le |-> o_dram_addr == exp_line_addr)
        else log_mismatch("line read address", exp_line_addr, $sampled(o_dram_addr));
    a_write_addr : assert property (@(posedge o_clk) disable iff (!i_rrst_x)
        o_dram_we |-> o_dram_addr == exp_waddr)
        else log_mismatch("write address", exp_waddr, $sampled(o_dram_addr));
    a_write_mask : assert property (@(posedge o_clk) disable iff (!i_rrst_x)
        o_dram_we |-> o_dram_mask == exp_mask)
        else log_mismatch("write mask", exp_mask, $sampled(o_dram_mask));
    a_write_data : assert property (@(posedge o_clk) disable iff (!i_rrst_x)
        o_dram_we |-> o_dram_wdata == exp_wdata)
        else log_mismatch("write data", exp_wdata, $sampled(o_dram_wdata));
    a_load_data : assert property (@(posedge o_clk) disable iff (!i_rrst_x)
        (done && done_load) |-> o_rdata == done_rdata)
        else log_mismatch("load data", done_rdata, $sampled(o_rdata));
    a_le_count : assert property (@(posedge o_clk) disable iff (!i_rrst_x)
        done |-> done_le == done_le_exp)
        else log_mismatch("line read pulses", done_le_exp, done_le);
    a_we_count : assert property (@(posedge o_clk) disable iff (!i_rrst_x)
        done |-> done_we == (done_load ? 0 : 1))
        else log_mismatch("write pulses", done_load ? 0 : 1, done_we);
    a_hit_busy : assert property (@(posedge o_clk) disable iff (!i_rrst_x)
        (done && done_load && done_le_exp == 0) |-> done_busy == 1)
        else log_mismatch("busy cycles on hit", 32'd1, done_busy);

    // pulses are counted on the edge where the DRAM takes them
    always @(posedge o_clk) begin
        if (o_dram_le) begin
            le_seen++;
        end
        if (o_dram_we) begin
            we_seen++;
        end
    end

    function automatic dcache_pkg::bmask_t lane_mask(input dcache_pkg::addr_t addr,
                                                     input dcache_pkg::acc_ctrl_t ctrl);
        dcache_pkg::bmask_t m;
        case (ctrl[1:0])
            2'd0:    m = 4'b0001 << addr[1:0];
            2'd1:    m = addr[1] ? 4'b1100 : 4'b0011;
            default: m = 4'b1111;
        endcase
        return m;
    endfunction

    function automatic dcache_pkg::word_t replicate_data(input dcache_pkg::word_t wdata,
                                                         input dcache_pkg::acc_ctrl_t ctrl);
        dcache_pkg::word_t w;
        case (ctrl[1:0])
            2'd0:    w = {4{wdata[7:0]}};
            2'd1:    w = {2{wdata[15:0]}};
            default: w = wdata;
        endcase
        return w;
    endfunction

    function automatic dcache_pkg::word_t expected_load(input dcache_pkg::addr_t addr,
                                                        input dcache_pkg::acc_ctrl_t ctrl);
        dcache_pkg::word_t w;
        w = ref_mem[addr[11:2]] >> {addr[1:0], 3'b000};
        case (ctrl[1:0])
            2'd0:    w = ctrl[2] ? {24'd0, w[7:0]} : {{24{w[7]}}, w[7:0]};
            2'd1:    w = ctrl[2] ? {16'd0, w[15:0]} : {{16{w[15]}}, w[15:0]};
            default: w = w;
        endcase
        return w;
    endfunction

    task automatic write_reference(input dcache_pkg::addr_t addr, input dcache_pkg::bmask_t mask,
                                   input dcache_pkg::word_t data);
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
            if (mask[b]) begin
                ref_mem[addr[11:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (o_busy && n < 200) begin
            n++;
            @(negedge o_clk);
        end
        busy_cycles = n;
        if (o_busy) begin
            report_failure("o_busy still high after 200 cycles");
        end
    endtask

    // starts on a falling edge with the cache idle
    task automatic run_request(input logic is_load, input dcache_pkg::addr_t addr,
                               input dcache_pkg::acc_ctrl_t ctrl, input dcache_pkg::word_t wdata,
                               input int le_exp);
        dcache_pkg::word_t exp_rdata;
        exp_rdata = '0;
        any_req   = 1'b1;
        le_seen   = 0;
        we_seen   = 0;
        if (is_load) begin
            exp_line_addr = {addr[31:4], 4'b0000};
            exp_rdata     = expected_load(addr, ctrl);
        end else begin
            exp_waddr = {addr[31:2], 2'b00};
            exp_mask  = lane_mask(addr, ctrl);
            exp_wdata = replicate_data(wdata, ctrl);
            write_reference(addr, exp_mask, exp_wdata);
        end
        i_addr  = addr;
        i_ctrl  = ctrl;
        i_wdata = wdata;
        i_rd_en = is_load;
        i_wr_en = !is_load;
        @(negedge o_clk);
        i_rd_en = 1'b0;
        i_wr_en = 1'b0;
        done    = 1'b0;
        wait_idle();
        done_load   = is_load;
        done_rdata  = exp_rdata;
        done_le_exp = le_exp;
        done_le     = le_seen;
        done_we     = we_seen;
        done_busy   = busy_cycles;
        done        = 1'b1;
    endtask

    task automatic read_access(input dcache_pkg::addr_t addr, input dcache_pkg::acc_ctrl_t ctrl,
                               input int le_exp);
        run_request(1'b1, addr, ctrl, 32'd0, le_exp);
    endtask

    task automatic write_access(input dcache_pkg::addr_t addr, input dcache_pkg::acc_ctrl_t ctrl,
                                input dcache_pkg::word_t wdata);
        run_request(1'b0, addr, ctrl, wdata, 0);
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = err_cnt;
    endtask

    task automatic end_test();
        // one more edge so the last request gets checked
        @(negedge o_clk);
        done = 1'b0;
        tests_run++;
        if (err_cnt == test_err_start) begin
            $display("[PASS] %s", test_name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s with %0d errors", test_name, err_cnt - test_err_start);
        end
    endtask

    initial begin
        i_rrst_x     = 1'b0;
        i_rd_en      = 1'b0;
        i_wr_en      = 1'b0;
        i_addr       = '0;
        i_wdata      = '0;
        i_ctrl       = '0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        any_req      = 1'b0;
        done         = 1'b0;
        test_name    = "reset";
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = (32'(i) << 2) ^ 32'h5a5a0000;
        end
        repeat (10) @(negedge o_clk);
        i_rrst_x = 1'b1;

        begin_test("reset_quiet");
        repeat (8) @(negedge o_clk);
        end_test();

        // word inside the line so the line address must drop the offset
        begin_test("load_miss");
        read_access(32'h108, 3'b010, 1);
        end_test();

        begin_test("load_hit");
        read_access(32'h108, 3'b010, 0);
        end_test();

        // bit 7 set in every byte so signed and unsigned loads differ
        begin_test("store_merge");
        for (int off = 0; off < 4; off++) begin
            write_access(32'h100 + off, 3'b000, 32'h5a5a5a80 + 32'(off * 8'h13));
        end
        write_access(32'h104, 3'b001, 32'h1234f00d);
        write_access(32'h106, 3'b001, 32'hffff7abc);
        for (int off = 0; off < 4; off++) begin
            read_access(32'h100 + off, 3'b000, 0);
            read_access(32'h100 + off, 3'b100, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            read_access(32'h104 + off, 3'b001, 0);
            read_access(32'h104 + off, 3'b101, 0);
        end
        read_access(32'h100, 3'b010, 0);
        read_access(32'h104, 3'b010, 0);
        end_test();

        begin_test("store_no_allocate");
        write_access(32'h202, 3'b001, 32'h0000c3a5);
        read_access(32'h202, 3'b001, 1);
        end_test();

        // each store follows the previous one while the DRAM is still stalled
        begin_test("back_to_back_stores");
        write_access(32'h300, 3'b010, 32'h11111111);
        write_access(32'h306, 3'b001, 32'h0000beef);
        write_access(32'h30b, 3'b000, 32'h0000007f);
        write_access(32'h30c, 3'b010, 32'hcafe0042);
        write_access(32'h102, 3'b000, 32'h00000044);
        write_access(32'h104, 3'b010, 32'h87654321);
        read_access(32'h304, 3'b010, 1);
        read_access(32'h300, 3'b010, 0);
        read_access(32'h308, 3'b010, 0);
        read_access(32'h30c, 3'b010, 0);
        read_access(32'h100, 3'b010, 0);
        read_access(32'h104, 3'b010, 0);
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
dcache_pkg.sv
dcache_store_if.sv
mem_req_decode.sv
dcache_ctrl.sv
dcache_store.sv
load_align.sv
dcache_top.sv
tb_dram_model.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_store_if.sv
      - mem_req_decode.sv
      - dcache_ctrl.sv
      - dcache_store.sv
      - load_align.sv
      - dcache_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_dram_model.sv
      - tb_dcache.sv
